/* matmul_pkg.sv */
// shared constants, bank and register codes, status bits, bus word and address union
package matmul_pkg;

  // matrix geometry, fixed because the address map depends on it
  localparam int mat_dim   = 4;
  localparam int idx_bits  = 2;
  localparam int mat_elems = mat_dim * mat_dim;

  // bank field of the word address
  localparam logic [1:0] bank_a   = 2'd0;
  localparam logic [1:0] bank_b   = 2'd1;
  localparam logic [1:0] bank_c   = 2'd2;
  localparam logic [1:0] bank_reg = 2'd3;

  // register indices inside the register bank
  localparam logic [3:0] reg_ctrl   = 4'd0;
  localparam logic [3:0] reg_status = 4'd1;

  // status word bit positions
  localparam int status_busy = 0;
  localparam int status_done = 1;

  // wishbone data word
  typedef logic [31:0] wb_word_t;

  // element view: bank, row, column
  typedef struct packed {
    logic [1:0]          bank;
    logic [idx_bits-1:0] row;
    logic [idx_bits-1:0] col;
  } mem_view_t;

  // register view: space must be bank_reg
  typedef struct packed {
    logic [1:0] space;
    logic [3:0] index;
  } regs_view_t;

  // word address, bus bits 7 to 2
  typedef union packed {
    mem_view_t  mem;
    regs_view_t regs;
  } matmul_addr_u;

endpackage

/* single_port_ram.sv */
// single-port matrix ram, 16 words, registered read-before-write output
`timescale 1ns/1ps

module single_port_ram #(
  parameter int DATA_WIDTH = 18
) (
  input  logic                              clk,
  input  logic [2*matmul_pkg::idx_bits-1:0] addr,
  input  logic                              we,
  input  logic [DATA_WIDTH-1:0]             d,
  output logic [DATA_WIDTH-1:0]             q
);

  // one word per matrix element, row then column
  logic [DATA_WIDTH-1:0] mem [matmul_pkg::mat_elems];

  // no reset, maps onto block ram
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= d;
    end
    // old contents on a write cycle
    q <= mem[addr];
  end

endmodule

/* matmul_regs.sv */
// wishbone slave: ctrl/status registers, address decode, ram port mux, bus hold while busy
`timescale 1ns/1ps

module matmul_regs #(
  parameter int DATA_WIDTH = 18
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              wb_cyc,
  input  logic                              wb_stb,
  input  logic                              wb_we,
  input  logic [7:0]                        wb_adr,
  input  matmul_pkg::wb_word_t              wb_dat_w,
  output matmul_pkg::wb_word_t              wb_dat_r,
  output logic                              wb_ack,
  output logic                              irq,
  output logic                              start,
  input  logic                              busy,
  input  logic [2*matmul_pkg::idx_bits-1:0] eng_a_addr,
  input  logic [2*matmul_pkg::idx_bits-1:0] eng_b_addr,
  input  logic [2*matmul_pkg::idx_bits-1:0] eng_c_addr,
  input  logic                              eng_c_we,
  input  logic [DATA_WIDTH-1:0]             eng_c_d,
  output logic [2*matmul_pkg::idx_bits-1:0] a_addr,
  output logic                              a_we,
  output logic [DATA_WIDTH-1:0]             a_d,
  output logic [2*matmul_pkg::idx_bits-1:0] b_addr,
  output logic                              b_we,
  output logic [DATA_WIDTH-1:0]             b_d,
  output logic [2*matmul_pkg::idx_bits-1:0] c_addr,
  output logic                              c_we,
  output logic [DATA_WIDTH-1:0]             c_d,
  input  logic [DATA_WIDTH-1:0]             a_q,
  input  logic [DATA_WIDTH-1:0]             b_q,
  input  logic [DATA_WIDTH-1:0]             c_q
);

  matmul_pkg::matmul_addr_u adr;
  logic [2*matmul_pkg::idx_bits-1:0] bus_elem;
  logic is_reg;
  logic is_mem;
  logic req;
  logic take;
  logic bus_wr;
  logic ctrl_go;
  logic busy_q;
  logic done;
  matmul_pkg::wb_word_t status_word;
  matmul_pkg::wb_word_t reg_rdata;

  // word address, byte lanes dropped
  assign adr      = wb_adr[7:2];
  assign is_reg   = (adr.regs.space == matmul_pkg::bank_reg);
  assign is_mem   = !is_reg;
  assign bus_elem = {adr.mem.row, adr.mem.col};

  // new request only, the ack cycle itself is not sampled again
  assign req = wb_cyc && wb_stb && !wb_ack;
  // matrix banks wait while the engine owns the rams
  assign take = req && !(is_mem && busy);
  assign bus_wr = take && wb_we && is_mem;

  // go bit only honoured when idle
  assign ctrl_go = take && wb_we && is_reg && !busy &&
                   (adr.regs.index == matmul_pkg::reg_ctrl) && wb_dat_w[0];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb_ack <= 1'b0;
      start  <= 1'b0;
      busy_q <= 1'b0;
      done   <= 1'b0;
    end else begin
      wb_ack <= take;
      // start pulse lines up with the ctrl write ack
      start  <= ctrl_go;
      busy_q <= busy;
      // sticky until the next run starts
      if (start) begin
        done <= 1'b0;
      end else if (busy_q && !busy) begin
        done <= 1'b1;
      end
    end
  end

  assign irq = done;

  // status: busy and done, rest zero
  always_comb begin
    status_word = '0;
    status_word[matmul_pkg::status_busy] = busy;
    status_word[matmul_pkg::status_done] = done;
  end

  // ctrl and unmapped indices read zero
  always_comb begin
    reg_rdata = '0;
    if (adr.regs.index == matmul_pkg::reg_status) begin
      reg_rdata = status_word;
    end
  end

  // address is held until ack, ram q lines up with the ack cycle
  always_comb begin
    case (adr.mem.bank)
      matmul_pkg::bank_a: wb_dat_r = matmul_pkg::wb_word_t'(a_q);
      matmul_pkg::bank_b: wb_dat_r = matmul_pkg::wb_word_t'(b_q);
      matmul_pkg::bank_c: wb_dat_r = matmul_pkg::wb_word_t'(c_q);
      default:            wb_dat_r = reg_rdata;
    endcase
  end

  // ram ports, engine when busy, bus otherwise
  // a and b are only read by the engine
  assign a_addr = busy ? eng_a_addr : bus_elem;
  assign a_we   = !busy && bus_wr && (adr.mem.bank == matmul_pkg::bank_a);
  assign a_d    = wb_dat_w[DATA_WIDTH-1:0];

  assign b_addr = busy ? eng_b_addr : bus_elem;
  assign b_we   = !busy && bus_wr && (adr.mem.bank == matmul_pkg::bank_b);
  assign b_d    = wb_dat_w[DATA_WIDTH-1:0];

  // c takes engine results while busy
  assign c_addr = busy ? eng_c_addr : bus_elem;
  assign c_we   = busy ? eng_c_we : (bus_wr && (adr.mem.bank == matmul_pkg::bank_c));
  assign c_d    = busy ? eng_c_d : wb_dat_w[DATA_WIDTH-1:0];

endmodule

/* matmul_engine.sv */
// multiply-accumulate sequencer: row/col/k counters, read pipeline, accumulator, c write
`timescale 1ns/1ps

module matmul_engine #(
  parameter int DATA_WIDTH = 18
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              start,
  output logic                              busy,
  output logic [2*matmul_pkg::idx_bits-1:0] a_addr,
  output logic [2*matmul_pkg::idx_bits-1:0] b_addr,
  output logic [2*matmul_pkg::idx_bits-1:0] c_addr,
  output logic                              c_we,
  output logic [DATA_WIDTH-1:0]             c_d,
  input  logic [DATA_WIDTH-1:0]             a_q,
  input  logic [DATA_WIDTH-1:0]             b_q
);

  // per element: mat_dim read issues, one drain, one c write
  localparam int phase_bits = $clog2(matmul_pkg::mat_dim + 2);
  localparam logic [phase_bits-1:0] phase_drain = phase_bits'(matmul_pkg::mat_dim);
  localparam logic [phase_bits-1:0] phase_write = phase_bits'(matmul_pkg::mat_dim + 1);

  // last row or column index
  localparam logic [matmul_pkg::idx_bits-1:0] last_idx =
    matmul_pkg::idx_bits'(matmul_pkg::mat_dim - 1);

  logic [phase_bits-1:0]           phase;
  logic [matmul_pkg::idx_bits-1:0] row;
  logic [matmul_pkg::idx_bits-1:0] col;
  logic [matmul_pkg::idx_bits-1:0] k;
  logic                            rd_valid;
  logic                            last_elem;
  logic                            kick;
  logic [DATA_WIDTH-1:0]           prod;
  logic [DATA_WIDTH-1:0]           acc;

  // k is the low part of the phase during the read phases
  assign k = phase[matmul_pkg::idx_bits-1:0];

  // a walks along the row, b down the column
  assign a_addr = {row, k};
  assign b_addr = {k, col};

  // result goes to c at row, col
  assign c_addr = {row, col};
  assign c_we   = busy && (phase == phase_write);
  assign c_d    = acc;

  assign last_elem = (row == last_idx) && (col == last_idx);

  // new run only from idle
  assign kick = start && !busy;

  // product kept modulo 2**DATA_WIDTH
  assign prod = a_q * b_q;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      busy     <= 1'b0;
      phase    <= '0;
      row      <= '0;
      col      <= '0;
      rd_valid <= 1'b0;
    end else begin
      // ram q valid the cycle after a read issue
      rd_valid <= busy && (phase < phase_drain);

      if (!busy) begin
        if (kick) begin
          busy  <= 1'b1;
          phase <= '0;
          row   <= '0;
          col   <= '0;
        end
      end else if (phase == phase_write) begin
        // element written, step to the next in row-major order
        phase <= '0;
        col   <= col + 1'b1;
        if (col == last_idx) begin
          row <= row + 1'b1;
        end
        // busy falls right after the final c write
        if (last_elem) begin
          busy <= 1'b0;
        end
      end else begin
        phase <= phase + 1'b1;
      end
    end
  end

  // accumulator
  // product k adds up while the read for k+1 is in flight
  // cleared at start and after each c write
  always_ff @(posedge clk) begin
    if (kick || c_we) begin
      acc <= '0;
    end else if (rd_valid) begin
      acc <= acc + prod;
    end
  end

endmodule

/* matmul_top.sv */
// top level: register block, multiply engine and the a, b, c matrix rams
`timescale 1ns/1ps

module matmul_top #(
  parameter int DATA_WIDTH = 18
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  logic [7:0]           wb_adr,
  input  matmul_pkg::wb_word_t wb_dat_w,
  output matmul_pkg::wb_word_t wb_dat_r,
  output logic                 wb_ack,
  output logic                 irq
);

  // engine handshake
  logic start;
  logic busy;

  // engine side ram requests
  logic [2*matmul_pkg::idx_bits-1:0] eng_a_addr;
  logic [2*matmul_pkg::idx_bits-1:0] eng_b_addr;
  logic [2*matmul_pkg::idx_bits-1:0] eng_c_addr;
  logic                              eng_c_we;
  logic [DATA_WIDTH-1:0]             eng_c_d;

  // muxed ram ports
  logic [2*matmul_pkg::idx_bits-1:0] a_addr;
  logic                              a_we;
  logic [DATA_WIDTH-1:0]             a_d;
  logic [DATA_WIDTH-1:0]             a_q;
  logic [2*matmul_pkg::idx_bits-1:0] b_addr;
  logic                              b_we;
  logic [DATA_WIDTH-1:0]             b_d;
  logic [DATA_WIDTH-1:0]             b_q;
  logic [2*matmul_pkg::idx_bits-1:0] c_addr;
  logic                              c_we;
  logic [DATA_WIDTH-1:0]             c_d;
  logic [DATA_WIDTH-1:0]             c_q;

  // bus slave and ram owner
  matmul_regs #(.DATA_WIDTH(DATA_WIDTH)) u_regs (
    .clk        (clk),
    .reset      (reset),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .irq        (irq),
    .start      (start),
    .busy       (busy),
    .eng_a_addr (eng_a_addr),
    .eng_b_addr (eng_b_addr),
    .eng_c_addr (eng_c_addr),
    .eng_c_we   (eng_c_we),
    .eng_c_d    (eng_c_d),
    .a_addr     (a_addr),
    .a_we       (a_we),
    .a_d        (a_d),
    .b_addr     (b_addr),
    .b_we       (b_we),
    .b_d        (b_d),
    .c_addr     (c_addr),
    .c_we       (c_we),
    .c_d        (c_d),
    .a_q        (a_q),
    .b_q        (b_q),
    .c_q        (c_q)
  );

  // sequencer, 96 cycles per run
  matmul_engine #(.DATA_WIDTH(DATA_WIDTH)) u_engine (
    .clk    (clk),
    .reset  (reset),
    .start  (start),
    .busy   (busy),
    .a_addr (eng_a_addr),
    .b_addr (eng_b_addr),
    .c_addr (eng_c_addr),
    .c_we   (eng_c_we),
    .c_d    (eng_c_d),
    .a_q    (a_q),
    .b_q    (b_q)
  );

  // matrix a
  single_port_ram #(.DATA_WIDTH(DATA_WIDTH)) u_ram_a (
    .clk  (clk),
    .addr (a_addr),
    .we   (a_we),
    .d    (a_d),
    .q    (a_q)
  );

  // matrix b
  single_port_ram #(.DATA_WIDTH(DATA_WIDTH)) u_ram_b (
    .clk  (clk),
    .addr (b_addr),
    .we   (b_we),
    .d    (b_d),
    .q    (b_q)
  );

  // result matrix c
  single_port_ram #(.DATA_WIDTH(DATA_WIDTH)) u_ram_c (
    .clk  (clk),
    .addr (c_addr),
    .we   (c_we),
    .d    (c_d),
    .q    (c_q)
  );

endmodule

/* matmul_assert.sv */
// concurrent wishbone handshake and status assertions, bound into the register block
`timescale 1ns/1ps

module matmul_assert (
  input logic clk,
  input logic reset,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic is_mem,
  input logic busy,
  input logic done,
  input logic irq,
  input logic start
);

  // failed assertions so far
  int fail_count = 0;

  // ack answers a request seen the cycle before
  ack_needs_request: assert property (@(posedge clk) disable iff (reset)
    $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
    else begin
      $error("ack rose without a bus request");
      fail_count++;
    end

  // single cycle pulse
  ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
    wb_ack |=> !wb_ack)
    else begin
      $error("ack held for two cycles");
      fail_count++;
    end

  // rams belong to the engine while busy
  no_mem_ack_busy: assert property (@(posedge clk) disable iff (reset)
    (wb_cyc && wb_stb && !wb_ack && is_mem && busy) |=> !wb_ack)
    else begin
      $error("matrix bank acked while engine busy");
      fail_count++;
    end

  // irq is the done bit
  irq_is_done: assert property (@(posedge clk) disable iff (reset)
    irq == done)
    else begin
      $error("irq differs from done");
      fail_count++;
    end

  // new run only from idle
  start_when_idle: assert property (@(posedge clk) disable iff (reset)
    start |-> !busy)
    else begin
      $error("start pulse while engine busy");
      fail_count++;
    end

endmodule

bind matmul_regs matmul_assert u_assert (
  .clk    (clk),
  .reset  (reset),
  .wb_cyc (wb_cyc),
  .wb_stb (wb_stb),
  .wb_ack (wb_ack),
  .is_mem (is_mem),
  .busy   (busy),
  .done   (done),
  .irq    (irq),
  .start  (start)
);

/* tb_matmul.sv */
// testbench: clock, reset, lfsr, wishbone tasks, reference model, stimulus table, compare tasks
`timescale 1ns/1ps

module tb_matmul;

  localparam int data_width   = 18;
  localparam int clk_period   = 100;
  localparam int drive_dly    = 5;
  localparam int bus_timeout  = 20;
  localparam int poll_timeout = 200;
  // 16 elements at 6 cycles each, a held read waits close to that
  localparam int min_hold_cycles = 90;

  // matrix patterns
  localparam int pat_zero  = 0;
  localparam int pat_ident = 1;
  localparam int pat_rand  = 2;
  localparam int pat_ones  = 3;
  localparam int pat_ovf   = 4;
  localparam int num_rows  = 6;

  logic                 clk;
  logic                 reset;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  logic [7:0]           wb_adr;
  matmul_pkg::wb_word_t wb_dat_w;
  matmul_pkg::wb_word_t wb_dat_r;
  logic                 wb_ack;
  logic                 irq;

  logic [31:0] lfsr_state;
  int          cycles = 0;

  // shadow copies, c holds the expected result
  logic [data_width-1:0] mat_a [matmul_pkg::mat_elems];
  logic [data_width-1:0] mat_b [matmul_pkg::mat_elems];
  logic [data_width-1:0] mat_c [matmul_pkg::mat_elems];

  // stimulus table: name, a pattern, b pattern
  string row_name [num_rows] = '{"zero_x_rand", "ident_x_rand", "rand_x_ident",
                                 "rand_x_rand", "ones_x_ones", "overflow"};
  int    row_a    [num_rows] = '{pat_zero, pat_ident, pat_rand, pat_rand, pat_ones, pat_ovf};
  int    row_b    [num_rows] = '{pat_rand, pat_rand, pat_ident, pat_rand, pat_ones, pat_ovf};

  matmul_top #(.DATA_WIDTH(data_width)) u_dut (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .irq      (irq)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // elapsed cycles for the status poll
  always @(posedge clk) cycles <= cycles + 1;

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // bound checker in the register block
  always @(posedge clk) begin
    if (u_dut.u_regs.u_assert.fail_count != 0) begin
      stop_run("a bus or status assertion in the register block failed");
    end
  end

  task automatic check_elem(input string name, input logic [data_width-1:0] exp,
                            input logic [data_width-1:0] act);
    if (act !== exp) begin
      stop_run($sformatf("ERROR %s expected=%h actual=%h", name, exp, act));
    end
  endtask

  task automatic check_status(input string name, input matmul_pkg::wb_word_t exp,
                              input matmul_pkg::wb_word_t act);
    if (act !== exp) begin
      stop_run($sformatf("ERROR %s expected=%h actual=%h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_run($sformatf("ERROR %s expected=%b actual=%b", name, exp, act));
    end
  endtask

  // fibonacci lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [data_width-1:0] rand_elem();
    logic [data_width-1:0] v;
    v = '0;
    for (int i = 0; i < data_width; i++) begin
      v = {v[data_width-2:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic matmul_pkg::wb_word_t rand_word();
    matmul_pkg::wb_word_t v;
    v = '0;
    for (int i = 0; i < 32; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic logic [data_width-1:0] pattern_elem(input int pat, input int r,
                                                         input int c);
    logic [data_width-1:0] v;
    case (pat)
      pat_zero:  v = '0;
      pat_ident: v = (r == c) ? data_width'(1) : '0;
      pat_rand:  v = rand_elem();
      pat_ones:  v = '1;
      default: begin
        // top bit forced so products and sums wrap
        v = rand_elem();
        v[data_width-1] = 1'b1;
      end
    endcase
    return v;
  endfunction

  // byte address: bank, row, col, two zero lane bits
  function automatic logic [7:0] elem_adr(input logic [1:0] bank, input int r, input int c);
    return {bank, 2'(r), 2'(c), 2'b00};
  endfunction

  function automatic logic [7:0] reg_adr(input logic [3:0] index);
    return {matmul_pkg::bank_reg, index, 2'b00};
  endfunction

  function automatic matmul_pkg::wb_word_t status_of(input logic busy, input logic done);
    matmul_pkg::wb_word_t v;
    v = '0;
    v[matmul_pkg::status_busy] = busy;
    v[matmul_pkg::status_done] = done;
    return v;
  endfunction

  function automatic logic [data_width-1:0] shadow_elem(input logic [1:0] bank, input int idx);
    case (bank)
      matmul_pkg::bank_a: return mat_a[idx];
      matmul_pkg::bank_b: return mat_b[idx];
      default:            return mat_c[idx];
    endcase
  endfunction

  // full precision sums, wrapped to the element width at the end
  task automatic compute_reference();
    logic [63:0] sum;
    for (int r = 0; r < matmul_pkg::mat_dim; r++) begin
      for (int c = 0; c < matmul_pkg::mat_dim; c++) begin
        sum = '0;
        for (int k = 0; k < matmul_pkg::mat_dim; k++) begin
          sum = sum + 64'(mat_a[r * 4 + k]) * 64'(mat_b[k * 4 + c]);
        end
        mat_c[r * 4 + c] = sum[data_width-1:0];
      end
    end
  endtask

  // master drops the request one cycle after seeing ack
  task automatic release_bus();
    @(posedge clk);
    #(drive_dly);
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
  endtask

  task automatic wb_write(input logic [7:0] adr, input matmul_pkg::wb_word_t data);
    int n;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    n = 1;
    @(posedge clk);
    #(drive_dly);
    while (!wb_ack) begin
      if (n >= bus_timeout) begin
        stop_run($sformatf("wb_write to %h got no ack within %0d cycles", adr, bus_timeout));
      end
      n++;
      @(posedge clk);
      #(drive_dly);
    end
    release_bus();
  endtask

  task automatic wb_read(input logic [7:0] adr, input int limit,
                         output matmul_pkg::wb_word_t data, output int waited);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    waited = 1;
    @(posedge clk);
    #(drive_dly);
    while (!wb_ack) begin
      if (waited >= limit) begin
        stop_run($sformatf("wb_read from %h got no ack within %0d cycles", adr, limit));
      end
      waited++;
      @(posedge clk);
      #(drive_dly);
    end
    // read data valid with ack
    data = wb_dat_r;
    release_bus();
  endtask

  task automatic read_word(input logic [7:0] adr, output matmul_pkg::wb_word_t data);
    int waited;
    wb_read(adr, bus_timeout, data, waited);
  endtask

  // poll status until done, then expect busy clear
  task automatic wait_done(input string name);
    matmul_pkg::wb_word_t status;
    int t0;
    t0 = cycles;
    read_word(reg_adr(matmul_pkg::reg_status), status);
    while (!status[matmul_pkg::status_done]) begin
      if (cycles - t0 > poll_timeout) begin
        stop_run($sformatf("%s: status poll saw no done within %0d cycles", name,
                           poll_timeout));
      end
      read_word(reg_adr(matmul_pkg::reg_status), status);
    end
    check_status({name, " final_status"}, status_of(1'b0, 1'b1), status);
  endtask

  task automatic load_matrices(input int pat_a, input int pat_b);
    int idx;
    for (int r = 0; r < matmul_pkg::mat_dim; r++) begin
      for (int c = 0; c < matmul_pkg::mat_dim; c++) begin
        idx = r * 4 + c;
        mat_a[idx] = pattern_elem(pat_a, r, c);
        wb_write(elem_adr(matmul_pkg::bank_a, r, c), 32'(mat_a[idx]));
      end
    end
    for (int r = 0; r < matmul_pkg::mat_dim; r++) begin
      for (int c = 0; c < matmul_pkg::mat_dim; c++) begin
        idx = r * 4 + c;
        mat_b[idx] = pattern_elem(pat_b, r, c);
        wb_write(elem_adr(matmul_pkg::bank_b, r, c), 32'(mat_b[idx]));
      end
    end
  endtask

  // whole bank against its shadow, upper word bits must be zero
  task automatic verify_bank(input string name, input logic [1:0] bank);
    matmul_pkg::wb_word_t rdata;
    int idx;
    for (int r = 0; r < matmul_pkg::mat_dim; r++) begin
      for (int c = 0; c < matmul_pkg::mat_dim; c++) begin
        idx = r * 4 + c;
        read_word(elem_adr(bank, r, c), rdata);
        if (rdata[31:data_width] !== '0) begin
          stop_run($sformatf("%s: bank %0d element %0d read back with upper bits set",
                             name, bank, idx));
        end
        check_elem($sformatf("%s bank%0d[%0d]", name, bank, idx),
                   shadow_elem(bank, idx), rdata[data_width-1:0]);
      end
    end
  endtask

  initial begin
    matmul_pkg::wb_word_t rdata;
    int    waited;
    string name;

    lfsr_state  = 32'h22ec_66ad;
    reset       = 1'b1;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    repeat (3) @(posedge clk);
    #(drive_dly);
    reset = 1'b0;

    // idle after reset
    read_word(reg_adr(matmul_pkg::reg_status), rdata);
    check_status("reset_status", status_of(1'b0, 1'b0), rdata);
    check_flag("reset_irq", 1'b0, irq);

    // plain ram read back on all banks
    for (int i = 0; i < matmul_pkg::mat_elems; i++) begin
      mat_a[i] = rand_elem();
      mat_b[i] = rand_elem();
      mat_c[i] = rand_elem();
      wb_write(elem_adr(matmul_pkg::bank_a, i / 4, i % 4), 32'(mat_a[i]));
      wb_write(elem_adr(matmul_pkg::bank_b, i / 4, i % 4), 32'(mat_b[i]));
      wb_write(elem_adr(matmul_pkg::bank_c, i / 4, i % 4), 32'(mat_c[i]));
    end
    verify_bank("readback", matmul_pkg::bank_a);
    verify_bank("readback", matmul_pkg::bank_b);
    verify_bank("readback", matmul_pkg::bank_c);

    // table rows, one full run each
    for (int t = 0; t < num_rows; t++) begin
      name = row_name[t];
      load_matrices(row_a[t], row_b[t]);
      compute_reference();
      wb_write(reg_adr(matmul_pkg::reg_ctrl), 32'h1);
      // register space still answers mid run
      read_word(reg_adr(matmul_pkg::reg_status), rdata);
      check_status({name, " status_running"}, status_of(1'b1, 1'b0), rdata);
      wait_done(name);
      check_flag({name, " irq"}, 1'b1, irq);
      verify_bank(name, matmul_pkg::bank_c);
    end

    // go bit clear starts nothing
    wb_write(reg_adr(matmul_pkg::reg_ctrl), 32'h0);
    read_word(reg_adr(matmul_pkg::reg_status), rdata);
    check_status("ctrl_zero_status", status_of(1'b0, 1'b1), rdata);
    check_flag("ctrl_zero_irq", 1'b1, irq);

    // restart drops done, then a c read is held off until the engine ends
    wb_write(reg_adr(matmul_pkg::reg_ctrl), 32'h1);
    check_flag("restart_irq", 1'b0, irq);
    wb_read(elem_adr(matmul_pkg::bank_c, 0, 0), poll_timeout, rdata, waited);
    if (waited < min_hold_cycles) begin
      stop_run($sformatf("matrix read acked after %0d cycles while engine still busy",
                         waited));
    end
    check_elem("held_read_c00", mat_c[0], rdata[data_width-1:0]);
    check_flag("held_read_irq", 1'b1, irq);
    read_word(reg_adr(matmul_pkg::reg_status), rdata);
    check_status("held_read_status", status_of(1'b0, 1'b1), rdata);

    // unmapped indices: read zero, writes have no effect
    for (int i = 2; i < 16; i++) begin
      wb_write(reg_adr(4'(i)), rand_word() | 32'h1);
      read_word(reg_adr(4'(i)), rdata);
      check_status($sformatf("unmapped_%0d", i), 32'h0, rdata);
    end
    read_word(reg_adr(matmul_pkg::reg_ctrl), rdata);
    check_status("ctrl_reads_zero", 32'h0, rdata);
    read_word(reg_adr(matmul_pkg::reg_status), rdata);
    check_status("unmapped_status", status_of(1'b0, 1'b1), rdata);
    check_flag("unmapped_irq", 1'b1, irq);
    verify_bank("unmapped", matmul_pkg::bank_a);
    verify_bank("unmapped", matmul_pkg::bank_b);
    verify_bank("unmapped", matmul_pkg::bank_c);

    if (u_dut.u_regs.u_assert.fail_count == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      stop_run("a bus or status assertion in the register block failed");
    end
  end

endmodule

/* matmul.f */
matmul_pkg.sv
single_port_ram.sv
matmul_regs.sv
matmul_engine.sv
matmul_top.sv
matmul_assert.sv
tb_matmul.sv
